/* design/sw_defs.svh */
`ifndef SW_DEFS_SVH
`define SW_DEFS_SVH

// Switch geometry
`define NUM_PORTS       4
`define NUM_BANKS       8
`define PAGES_PER_BANK  16
`define WORDS_PER_PAGE  8
`define WORD_W          16
`define ECC_W           8

// Derived widths
`define PAGE_W          (`WORD_W * `WORDS_PER_PAGE)
`define PORT_ID_W       2
`define BANK_ID_W       3
`define PAGE_IDX_W      4
`define FILL_W          5   // Holds 0 to PAGES_PER_BANK
`define BIT_IDX_W       7   // Selects one of the PAGE_W data bits

// Flow control
`define PORT_CREDITS    2

// Port moves on once its bank holds more pages than this
`define REBIND_LEVEL    12

`endif

/* design/sw_pkg.sv */
`default_nettype none

`include "sw_defs.svh"

package sw_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`PAGE_W-1:0]     page_t;     // Word 0 in bits 15:0
    typedef logic [`ECC_W-1:0]      ecc_t;
    typedef logic [`PORT_ID_W-1:0]  port_id_t;
    typedef logic [`BANK_ID_W-1:0]  bank_id_t;
    typedef logic [`PAGE_IDX_W-1:0] page_idx_t;

    typedef struct packed {
        bank_id_t  bank;
        page_idx_t idx;
    } page_loc_t;

    // Page write toward the store, code computed before any injected flip
    typedef struct packed {
        page_loc_t loc;
        page_t     data;
        ecc_t      code;
    } page_wr_t;

    typedef struct packed {
        port_id_t  port;
        page_loc_t loc;
    } page_done_t;

    typedef struct packed {
        page_t data;
        logic  corrected;
    } rd_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [`BIT_IDX_W-1:0] bit_idx;
    } err_inj_t;

endpackage

`default_nettype wire

/* design/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    assign not_empty = count != '0;
    assign do_pop    = pop && not_empty;
    assign pop_data  = mem[rd_ptr];  // Head is visible with not_empty

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + cnt_w'(push) - cnt_w'(do_pop);
            credit <= do_pop;  // One credit back per popped entry
        end
    end

endmodule

`default_nettype wire

/* design/ecc_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module ecc_encoder (
    input  sw_pkg::page_t data,
    output sw_pkg::ecc_t  code
);

    // Code word positions 1 to 136, check bits sit at the powers of two
    localparam int cw_len = `PAGE_W + `ECC_W;

    always_comb begin
        int d;
        code = '0;
        d = 0;
        for (int pos = 1; pos <= cw_len; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                for (int b = 0; b < `ECC_W; b++) begin
                    if (pos[b]) begin
                        code[b] = code[b] ^ data[d];
                    end
                end
                d++;  // Next data bit
            end
        end
    end

endmodule

`default_nettype wire

/* design/ecc_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module ecc_decoder (
    input  sw_pkg::page_t   data,
    input  sw_pkg::ecc_t    code,
    output sw_pkg::rd_rsp_t fixed
);

    localparam int cw_len = `PAGE_W + `ECC_W;

    sw_pkg::ecc_t recalc;
    sw_pkg::ecc_t syndrome;

    ecc_encoder i_recalc (
        .data (data),
        .code (recalc)
    );

    // Syndrome is the code word position of a single flipped bit
    assign syndrome = recalc ^ code;

    always_comb begin
        int d;
        fixed.data      = data;
        fixed.corrected = 1'b0;
        d = 0;
        for (int pos = 1; pos <= cw_len; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (syndrome == sw_pkg::ecc_t'(pos)) begin
                    fixed.data[d]   = ~data[d];
                    fixed.corrected = 1'b1;
                end
                d++;
            end
        end
        // A power-of-two syndrome is a check bit error, data left as is
    end

endmodule

`default_nettype wire

/* design/page_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module page_assembler #(
    parameter sw_pkg::port_id_t port_id = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_avail,
    input  sw_pkg::word_t      word_in,
    output logic               word_pop,
    output logic               alloc_req,
    input  logic               alloc_gnt,
    input  sw_pkg::page_loc_t  alloc_loc,
    input  sw_pkg::err_inj_t   err_inj,
    output logic               inj_taken,
    output sw_pkg::page_wr_t   page_wr,
    output logic               page_wr_en,
    output sw_pkg::page_done_t page_done,
    output logic               done_valid
);

    localparam int cnt_w = $clog2(`WORDS_PER_PAGE + 1);

    sw_pkg::page_t    page_q;
    sw_pkg::page_t    inj_mask;
    sw_pkg::ecc_t     code;
    logic [cnt_w-1:0] cnt_q;
    logic             full;
    logic             fire;

    assign full      = cnt_q == cnt_w'(`WORDS_PER_PAGE);
    assign word_pop  = word_avail && !full;  // Stalls while a page waits for a grant
    assign alloc_req = full;
    assign fire      = full && alloc_gnt;

    ecc_encoder i_ecc_encoder (
        .data (page_q),
        .code (code)
    );

    // Flip lands after encoding so the store sees a correctable error
    assign inj_mask = err_inj.valid ? (sw_pkg::page_t'(1) << err_inj.bit_idx) : '0;

    always_comb begin
        page_wr.loc    = alloc_loc;
        page_wr.data   = page_q ^ inj_mask;
        page_wr.code   = code;
        page_done.port = port_id;
        page_done.loc  = alloc_loc;
    end

    assign page_wr_en = fire;
    assign done_valid = fire;
    assign inj_taken  = fire && err_inj.valid;

    // New word enters at the top, word 0 ends in the low bits
    always_ff @(posedge clk) begin
        if (word_pop) begin
            page_q <= {word_in, page_q[`PAGE_W-1:`WORD_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (fire) begin
            cnt_q <= '0;
        end else if (word_pop) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/bank_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module bank_allocator (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`NUM_PORTS-1:0]                alloc_req,
    output logic [`NUM_PORTS-1:0]                alloc_gnt,
    output sw_pkg::page_loc_t [`NUM_PORTS-1:0]   alloc_loc
);

    // Fill count doubles as the next free page index
    logic [`FILL_W-1:0] fill_q [`NUM_BANKS];
    logic [`FILL_W-1:0] fill_d [`NUM_BANKS];
    sw_pkg::bank_id_t   bind_q [`NUM_PORTS];
    sw_pkg::bank_id_t   bind_d [`NUM_PORTS];
    logic [`NUM_BANKS-1:0] held_q;
    logic [`NUM_BANKS-1:0] held_d;

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            alloc_gnt[p] = alloc_req[p] &&
                           (fill_q[bind_q[p]] < `FILL_W'(`PAGES_PER_BANK));
            alloc_loc[p].bank = bind_q[p];
            alloc_loc[p].idx  = fill_q[bind_q[p]][`PAGE_IDX_W-1:0];
        end
    end

    // Ports never share a bank, so each grant bumps its own counter
    always_comb begin
        sw_pkg::bank_id_t   b;
        logic [`FILL_W-1:0] nf;
        logic               found;
        b      = '0;
        nf     = '0;
        found  = 1'b0;
        fill_d = fill_q;
        bind_d = bind_q;
        held_d = held_q;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            b = bind_q[p];
            if (alloc_gnt[p]) begin
                nf = fill_q[b] + 1'b1;
                fill_d[b] = nf;
                if (nf > `FILL_W'(`REBIND_LEVEL)) begin
                    found = 1'b0;
                    // Lowest unheld bank still at or under the level
                    for (int k = 0; k < `NUM_BANKS; k++) begin
                        if (!found && !held_d[k] && fill_d[k] <= `FILL_W'(`REBIND_LEVEL)) begin
                            found     = 1'b1;
                            bind_d[p] = sw_pkg::bank_id_t'(k);
                            held_d[k] = 1'b1;
                            held_d[b] = 1'b0;  // Old bank released
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `NUM_BANKS; k++) begin
                fill_q[k] <= '0;
            end
            for (int p = 0; p < `NUM_PORTS; p++) begin
                bind_q[p] <= sw_pkg::bank_id_t'(p);  // Port i starts on bank i
            end
            held_q <= `NUM_BANKS'((1 << `NUM_PORTS) - 1);
        end else begin
            fill_q <= fill_d;
            bind_q <= bind_d;
            held_q <= held_d;
        end
    end

endmodule

`default_nettype wire

/* design/page_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module page_store (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`NUM_PORTS-1:0]              wr_en,
    input  sw_pkg::page_wr_t [`NUM_PORTS-1:0]  wr,
    input  logic                               rd_en,
    input  sw_pkg::page_loc_t                  rd_loc,
    output logic                               rd_valid,
    output sw_pkg::rd_rsp_t                    rd_rsp
);

    typedef struct packed {
        sw_pkg::ecc_t  code;
        sw_pkg::page_t data;
    } entry_t;

    entry_t            mem [`NUM_BANKS][`PAGES_PER_BANK];
    sw_pkg::page_loc_t addr_q;
    entry_t            rd_q;
    sw_pkg::rd_rsp_t   fixed;
    logic              addr_valid_q;
    logic              rd_valid_q;

    // Lanes always target different banks
    always_ff @(posedge clk) begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (wr_en[p]) begin
                mem[wr[p].loc.bank][wr[p].loc.idx] <= {wr[p].code, wr[p].data};
            end
        end
    end

    // Address latch, then the synchronous array read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            addr_q <= rd_loc;
        end
        if (addr_valid_q) begin
            rd_q <= mem[addr_q.bank][addr_q.idx];
        end
        if (rd_valid_q) begin
            rd_rsp <= fixed;
        end
    end

    ecc_decoder i_ecc_decoder (
        .data  (rd_q.data),
        .code  (rd_q.code),
        .fixed (fixed)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid_q <= 1'b0;
            rd_valid_q   <= 1'b0;
            rd_valid     <= 1'b0;
        end else begin
            addr_valid_q <= rd_en;
            rd_valid_q   <= addr_valid_q;
            rd_valid     <= rd_valid_q;
        end
    end

endmodule

`default_nettype wire

/* design/shared_buffer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module shared_buffer_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`NUM_PORTS-1:0]                word_valid,
    input  sw_pkg::word_t [`NUM_PORTS-1:0]       word_data,
    output logic [`NUM_PORTS-1:0]                word_credit,
    output sw_pkg::page_done_t [`NUM_PORTS-1:0]  page_done,
    output logic [`NUM_PORTS-1:0]                done_valid,
    input  logic                                 rd_req_valid,
    input  sw_pkg::page_loc_t                    rd_req,
    output logic                                 rd_credit,
    output logic                                 rd_rsp_valid,
    output sw_pkg::rd_rsp_t                      rd_rsp,
    input  sw_pkg::err_inj_t                     err_inj
);

    sw_pkg::word_t [`NUM_PORTS-1:0]     fifo_word;
    logic [`NUM_PORTS-1:0]              word_avail;
    logic [`NUM_PORTS-1:0]              word_pop;
    logic [`NUM_PORTS-1:0]              alloc_req;
    logic [`NUM_PORTS-1:0]              alloc_gnt;
    sw_pkg::page_loc_t [`NUM_PORTS-1:0] alloc_loc;
    sw_pkg::page_wr_t [`NUM_PORTS-1:0]  page_wr;
    logic [`NUM_PORTS-1:0]              page_wr_en;
    logic [`NUM_PORTS-1:0]              inj_taken;  // Port that consumed the flip
    sw_pkg::page_loc_t                  rd_loc;
    logic                               rd_avail;

    for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_port
        credit_fifo #(
            .payload_t (sw_pkg::word_t),
            .depth     (`PORT_CREDITS)
        ) i_word_fifo (
            .clk       (clk),
            .rst       (rst),
            .push      (word_valid[g]),
            .push_data (word_data[g]),
            .pop       (word_pop[g]),
            .pop_data  (fifo_word[g]),
            .not_empty (word_avail[g]),
            .credit    (word_credit[g])
        );

        page_assembler #(
            .port_id (sw_pkg::port_id_t'(g))
        ) i_page_assembler (
            .clk        (clk),
            .rst        (rst),
            .word_avail (word_avail[g]),
            .word_in    (fifo_word[g]),
            .word_pop   (word_pop[g]),
            .alloc_req  (alloc_req[g]),
            .alloc_gnt  (alloc_gnt[g]),
            .alloc_loc  (alloc_loc[g]),
            .err_inj    (err_inj),
            .inj_taken  (inj_taken[g]),
            .page_wr    (page_wr[g]),
            .page_wr_en (page_wr_en[g]),
            .page_done  (page_done[g]),
            .done_valid (done_valid[g])
        );
    end

    bank_allocator i_bank_allocator (
        .clk       (clk),
        .rst       (rst),
        .alloc_req (alloc_req),
        .alloc_gnt (alloc_gnt),
        .alloc_loc (alloc_loc)
    );

    // Head request is popped as soon as it arrives
    credit_fifo #(
        .payload_t (sw_pkg::page_loc_t),
        .depth     (`PORT_CREDITS)
    ) i_rd_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (rd_req_valid),
        .push_data (rd_req),
        .pop       (rd_avail),
        .pop_data  (rd_loc),
        .not_empty (rd_avail),
        .credit    (rd_credit)
    );

    page_store i_page_store (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (page_wr_en),
        .wr       (page_wr),
        .rd_en    (rd_avail),
        .rd_loc   (rd_loc),
        .rd_valid (rd_rsp_valid),
        .rd_rsp   (rd_rsp)
    );

endmodule

`default_nettype wire

/* verification/shared_buffer_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module shared_buffer_chk (
    input wire logic                                clk,
    input wire logic                                rst,
    input wire logic [`NUM_PORTS-1:0]               word_valid,
    input wire logic [`NUM_PORTS-1:0]               word_credit,
    input wire sw_pkg::page_done_t [`NUM_PORTS-1:0] page_done,
    input wire logic [`NUM_PORTS-1:0]               done_valid,
    input wire logic                                rd_req_valid,
    input wire logic                                rd_credit,
    input wire logic                                rd_rsp_valid,
    input wire logic [`NUM_PORTS-1:0]               inj_taken
);

    int out_q [`NUM_PORTS];       // Words pushed and not yet credited
    int rd_out_q;
    int bank_used [`NUM_BANKS];   // Pages reported per bank so far

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                out_q[p] <= 0;
            end
            for (int k = 0; k < `NUM_BANKS; k++) begin
                bank_used[k] <= 0;
            end
            rd_out_q <= 0;
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                out_q[p] <= out_q[p] + int'(word_valid[p]) - int'(word_credit[p]);
                if (done_valid[p]) begin
                    bank_used[page_done[p].loc.bank] <= bank_used[page_done[p].loc.bank] + 1;
                end
            end
            rd_out_q <= rd_out_q + int'(rd_req_valid) - int'(rd_credit);
        end
    end

    for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_port_chk
        a_push_has_credit: assert property (@(posedge clk) disable iff (rst)
            word_valid[g] |-> (out_q[g] - int'(word_credit[g])) < `PORT_CREDITS)
            else $error("word pushed on port %0d without a credit", g);
        a_credit_was_spent: assert property (@(posedge clk) disable iff (rst)
            word_credit[g] |-> out_q[g] > 0)
            else $error("credit returned on port %0d that was never spent", g);
        a_bank_not_full: assert property (@(posedge clk) disable iff (rst)
            done_valid[g] |-> bank_used[page_done[g].loc.bank] < `PAGES_PER_BANK)
            else $error("page_done on port %0d names a full bank", g);
    end

    a_rd_credit_was_spent: assert property (@(posedge clk) disable iff (rst)
        rd_credit |-> rd_out_q > 0)
        else $error("read credit returned that was never spent");

    // One flip lands in one page only
    a_inj_single_page: assert property (@(posedge clk) disable iff (rst)
        $onehot0(inj_taken))
        else $error("injected flip applied to more than one page");

    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> (word_credit == '0 && done_valid == '0 && !rd_credit && !rd_rsp_valid))
        else $error("pulse output active right after reset");

endmodule

bind shared_buffer_ctrl shared_buffer_chk i_shared_buffer_chk (
    .clk          (clk),
    .rst          (rst),
    .word_valid   (word_valid),
    .word_credit  (word_credit),
    .page_done    (page_done),
    .done_valid   (done_valid),
    .rd_req_valid (rd_req_valid),
    .rd_credit    (rd_credit),
    .rd_rsp_valid (rd_rsp_valid),
    .inj_taken    (inj_taken)
);

`default_nettype wire

/* verification/shared_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_defs.svh"

module shared_buffer_tb;

    localparam int max_pages = 64;
    localparam int num_locs  = `NUM_BANKS * `PAGES_PER_BANK;

    logic                               clk;
    logic                               rst;
    logic [`NUM_PORTS-1:0]              word_valid;
    sw_pkg::word_t [`NUM_PORTS-1:0]     word_data;
    logic [`NUM_PORTS-1:0]              word_credit;
    sw_pkg::page_done_t [`NUM_PORTS-1:0] page_done;
    logic [`NUM_PORTS-1:0]              done_valid;
    logic                               rd_req_valid;
    sw_pkg::page_loc_t                  rd_req;
    logic                               rd_credit;
    logic                               rd_rsp_valid;
    sw_pkg::rd_rsp_t                    rd_rsp;
    sw_pkg::err_inj_t                   err_inj;

    shared_buffer_ctrl i_shared_buffer_ctrl (
        .clk          (clk),
        .rst          (rst),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .word_credit  (word_credit),
        .page_done    (page_done),
        .done_valid   (done_valid),
        .rd_req_valid (rd_req_valid),
        .rd_req       (rd_req),
        .rd_credit    (rd_credit),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp       (rd_rsp),
        .err_inj      (err_inj)
    );

    // Host side state
    logic [31:0]   rng = 32'd85;
    int            cyc;
    int            errors;
    int            corr_err;
    int            tests_run;
    int            tests_failed;
    logic          timed_out;
    int            credits [`NUM_PORTS];
    int            words_left [`NUM_PORTS];
    sw_pkg::page_t cur_page [`NUM_PORTS];
    int            cur_cnt [`NUM_PORTS];
    sw_pkg::page_t pushed [`NUM_PORTS][max_pages];
    int            pushed_n [`NUM_PORTS];
    int            done_n [`NUM_PORTS];
    int            log_bank [`NUM_PORTS][max_pages];
    int            log_idx [`NUM_PORTS][max_pages];
    int            done_total;
    int            bank_next [`NUM_BANKS];  // Expected next page index
    sw_pkg::page_t model_mem [num_locs];
    logic          model_vld [num_locs];

    // Read and injection state
    sw_pkg::page_loc_t to_read_q [$];
    sw_pkg::page_loc_t issued_q [$];
    sw_pkg::page_loc_t pend_loc_q [$];
    int                pend_due_q [$];
    int                rd_cred;
    int                reads_done;
    logic              inj_arm;
    logic              inj_seen;
    logic              inj_done;
    logic              inj_read;
    int                inj_addr;
    logic [6:0]        inj_bit;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // All DUT inputs and all observation live on the falling edge
    always @(negedge clk) begin
        int a;
        if (!rst) begin
            if (inj_seen) begin
                err_inj  = '0;
                inj_seen = 1'b0;
            end
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (word_credit[p]) begin
                    credits[p]++;
                    assert (credits[p] <= `PORT_CREDITS)
                        else mismatch($sformatf("port %0d got more credits than spent", p));
                end
                if (done_valid[p]) begin
                    a = int'(page_done[p].loc.bank) * `PAGES_PER_BANK + int'(page_done[p].loc.idx);
                    assert (page_done[p].port == p[1:0])
                        else mismatch($sformatf("page_done port field wrong on port %0d", p));
                    assert (!model_vld[a])
                        else mismatch($sformatf("location %0d reported twice", a));
                    assert (int'(page_done[p].loc.idx) == bank_next[page_done[p].loc.bank])
                        else mismatch($sformatf("bank %0d index out of order", page_done[p].loc.bank));
                    if (done_n[p] == 0) begin
                        assert (page_done[p].loc.bank == p[2:0] && page_done[p].loc.idx == 0)
                            else mismatch($sformatf("first page of port %0d misplaced", p));
                    end
                    bank_next[page_done[p].loc.bank]++;
                    model_mem[a] = pushed[p][done_n[p]];
                    model_vld[a] = 1'b1;
                    log_bank[p][done_n[p]] = int'(page_done[p].loc.bank);
                    log_idx[p][done_n[p]]  = int'(page_done[p].loc.idx);
                    done_n[p]++;
                    done_total++;
                    if (err_inj.valid) begin
                        inj_seen = 1'b1;
                        inj_arm  = 1'b0;
                        inj_done = 1'b1;
                        inj_addr = a;
                    end
                end
            end
            if (inj_arm) begin
                err_inj = {1'b1, inj_bit};
            end
            if (rd_credit) begin
                rd_cred++;
                pend_loc_q.push_back(issued_q.pop_front());
                pend_due_q.push_back(cyc + 2);
            end
            if (rd_rsp_valid) begin
                if (pend_due_q.size() == 0) begin
                    mismatch("read response without a request");
                end else begin
                    a = int'(pend_loc_q[0].bank) * `PAGES_PER_BANK + int'(pend_loc_q[0].idx);
                    assert (pend_due_q[0] == cyc)
                        else mismatch($sformatf("read response for %0d at wrong cycle", a));
                    assert (rd_rsp.data == model_mem[a])
                        else mismatch($sformatf("read data differs at location %0d", a));
                    assert (rd_rsp.corrected == (inj_done && a == inj_addr))
                        else begin
                            mismatch($sformatf("corrected flag wrong at location %0d", a));
                            corr_err++;
                        end
                    if (inj_done && a == inj_addr) begin
                        inj_read = 1'b1;
                    end
                    void'(pend_loc_q.pop_front());
                    void'(pend_due_q.pop_front());
                    reads_done++;
                end
            end else if (pend_due_q.size() != 0 && pend_due_q[0] < cyc) begin
                mismatch("read response missing");
                void'(pend_loc_q.pop_front());
                void'(pend_due_q.pop_front());
                reads_done++;
            end
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (words_left[p] > 0 && credits[p] > 0) begin
                    rng = xorshift(rng);
                    word_valid[p] = 1'b1;
                    word_data[p]  = rng[15:0];
                    cur_page[p][cur_cnt[p]*`WORD_W +: `WORD_W] = rng[15:0];
                    cur_cnt[p]++;
                    if (cur_cnt[p] == `WORDS_PER_PAGE) begin
                        pushed[p][pushed_n[p]] = cur_page[p];
                        pushed_n[p]++;
                        cur_cnt[p] = 0;
                    end
                    credits[p]--;
                    words_left[p]--;
                end else begin
                    word_valid[p] = 1'b0;
                end
            end
            if (rd_cred > 0 && to_read_q.size() != 0) begin
                rd_req_valid = 1'b1;
                rd_req       = to_read_q.pop_front();
                issued_q.push_back(rd_req);
                rd_cred--;
            end else begin
                rd_req_valid = 1'b0;
            end
        end
    end

    task automatic wait_pages(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (done_total < target && !timed_out) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                $display("Timeout: %s never completed", what);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_credits_home(input int limit);
        int n;
        logic home;
        n = 0;
        home = 1'b0;
        while (!home && !timed_out) begin
            @(posedge clk);
            home = 1'b1;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (credits[p] != `PORT_CREDITS || words_left[p] != 0) home = 1'b0;
            end
            n++;
            if (n > limit) begin
                $display("Timeout: word credits never all came back");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_reads(input int target, input int limit);
        int n;
        n = 0;
        while (reads_done < target && !timed_out) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                $display("Timeout: read responses never all arrived");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_quiet(input int quiet, input int limit);
        int n;
        int still;
        int last;
        n = 0;
        still = 0;
        last = done_total;
        while (still < quiet && !timed_out) begin
            @(posedge clk);
            if (done_total == last) still++;
            else still = 0;
            last = done_total;
            n++;
            if (n > limit) begin
                $display("Timeout: page completions never stopped");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report(input int num, input string name, input logic ok);
        tests_run++;
        if (!ok) tests_failed++;
        $display("test %0d %s: %s", num, name, ok ? "ok" : "failed");
    endtask

    initial begin
        int e0;
        int c0;
        int snap;
        logic ok;
        int left_snap [`NUM_PORTS];
        rst = 1'b1;
        word_valid = '0;
        word_data = '0;
        rd_req_valid = 1'b0;
        rd_req = '0;
        err_inj = '0;
        cyc = 0;
        errors = 0;
        corr_err = 0;
        timed_out = 1'b0;
        done_total = 0;
        rd_cred = `PORT_CREDITS;
        reads_done = 0;
        inj_arm = 1'b0;
        inj_seen = 1'b0;
        inj_done = 1'b0;
        inj_read = 1'b0;
        inj_addr = -1;
        inj_bit = 7'd77;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            credits[p] = `PORT_CREDITS;
            words_left[p] = 0;
            cur_cnt[p] = 0;
            pushed_n[p] = 0;
            done_n[p] = 0;
        end
        for (int k = 0; k < `NUM_BANKS; k++) bank_next[k] = 0;
        for (int a = 0; a < num_locs; a++) model_vld[a] = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // All ports at once, two pages each
        @(posedge clk);
        e0 = errors;
        for (int p = 0; p < `NUM_PORTS; p++) words_left[p] = 2 * `WORDS_PER_PAGE;
        wait_pages(8, 2000, "parallel page streaming");
        wait_credits_home(200);
        report(1, "credits", !timed_out && errors == e0);
        report(2, "placement", !timed_out && errors == e0);

        // Port 0 runs past the rebind level of bank 0
        e0 = errors;
        words_left[0] = 12 * `WORDS_PER_PAGE;
        wait_pages(20, 4000, "port 0 streaming");
        ok = !timed_out && done_n[0] == 14;
        for (int k = 0; k < 13; k++) begin
            assert (log_bank[0][k] == 0 && log_idx[0][k] == k)
                else mismatch($sformatf("port 0 page %0d not at bank 0 index %0d", k, k));
        end
        assert (log_bank[0][13] == 4 && log_idx[0][13] == 0)
            else mismatch("port 0 page 13 not rebound to bank 4 index 0");
        report(3, "rebinding", ok && errors == e0);

        // One flipped bit on a port 1 page, then read everything back
        inj_arm = 1'b1;
        words_left[1] = `WORDS_PER_PAGE;
        wait_pages(21, 1000, "injected page");
        repeat (3) @(posedge clk);
        e0 = errors;
        c0 = corr_err;
        snap = 0;
        for (int a = 0; a < num_locs; a++) begin
            if (model_vld[a]) begin
                to_read_q.push_back(sw_pkg::page_loc_t'(a));
                snap++;
            end
        end
        wait_reads(snap, 20 * snap + 100);
        report(4, "read-back", !timed_out && (errors - e0) == (corr_err - c0));
        report(5, "correction", !timed_out && inj_done && inj_read && corr_err == c0);

        // Stream until every port stalls on a full bank
        e0 = errors;
        for (int p = 0; p < `NUM_PORTS; p++) words_left[p] = 40 * `WORDS_PER_PAGE;
        wait_quiet(300, 30000);
        snap = done_total;
        ok = !timed_out && done_total <= num_locs;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            left_snap[p] = words_left[p];
            assert (credits[p] == 0 && words_left[p] > 0)
                else mismatch($sformatf("port %0d did not stall", p));
        end
        repeat (100) @(posedge clk);
        assert (done_total == snap)
            else mismatch("page_done appeared after all banks filled");
        // Any returned credit would have been spent on a new word
        for (int p = 0; p < `NUM_PORTS; p++) begin
            assert (words_left[p] == left_snap[p])
                else mismatch($sformatf("word credit returned on port %0d after stall", p));
        end
        report(6, "back-pressure", ok && errors == e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/sw_pkg.sv
design/credit_fifo.sv
design/ecc_encoder.sv
design/ecc_decoder.sv
design/page_assembler.sv
design/bank_allocator.sv
design/page_store.sv
design/shared_buffer_ctrl.sv
verification/shared_buffer_chk.sv
verification/shared_buffer_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the shared buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module shared_buffer_tb -f vlog.f -o sim_shared_buffer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_shared_buffer > run.log 2>&1
status=$?
cat run.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" run.log; then
    exit 1
fi
exit 0
